//--- all.f
+incdir+design
design/flash_pkg.sv
design/bubble_pkg.sv
design/load_request_reg.sv
design/flash_reader.sv
design/loop_map_table.sv
design/load_sequencer.sv
design/spi_loader_top.sv
verif/spi_flash_model.sv
verif/tb_spi_loader.sv

//--- design/bubble_pkg.sv
package bubble_pkg;

    // bubble buffer RAM write address
    typedef logic [14:0] buf_addr_t;

    // bad-loop table index, one entry per loop
    typedef logic [11:0] map_addr_t;

    // request kind
    typedef enum logic
    {
        KIND_BOOT = 1'b0,          // bootloader plus loop map
        KIND_PAGE = 1'b1           // one data page through the map
    } load_kind_t;

    // sequencer phases
    typedef enum logic [2:0]
    {
        PH_IDLE,                   // waiting for go
        PH_CMD,                    // read command going out
        PH_BOOT,                   // bootloader bits to buffer
        PH_MAP,                    // map bits to buffer and table
        PH_HEAD,                   // header loops from table
        PH_DATA                    // data loops from table and flash
    } seq_phase_t;

endpackage

//--- design/flash_pkg.sv
package flash_pkg;

    // image slot within the flash, eight images max
    typedef logic [2:0] img_num_t;

    // page within one image
    typedef logic [11:0] page_num_t;

    // 24 bit read address as sent after the command byte
    typedef struct packed
    {
        logic [1:0] pad_hi;        // always zero
        img_num_t   img;           // image select
        page_num_t  page;          // page number
        logic [6:0] byte_off;      // byte in page, loads start at zero
    } flash_addr_t;

    // byte offset into a page is always zero here

endpackage

//--- design/flash_reader.sv
`include "spi_loader_settings.svh"

module flash_reader
(
    input  logic                    MCLK,
    input  logic                    rst,
    input  flash_pkg::flash_addr_t  flash_addr,
    input  logic                    cmd_start,       // pulse, begins a read
    input  logic                    cmd_end,         // pulse, releases the flash
    input  logic                    bit_req,         // pulse, one bit wanted
    input  logic                    flash_miso,
    output logic                    cmd_done,
    output logic                    bit_valid,       // two cycles after bit_req
    output logic                    bit_data,
    output logic                    flash_cs_n,
    output logic                    flash_sclk,
    output logic                    flash_mosi
);

    typedef enum logic [1:0]
    {
        FR_IDLE,
        FR_CMD,                                      // shifting command and address
        FR_READY,                                    // cs low, waiting for bit requests
        FR_READ                                      // sclk low half of a data bit
    } fr_state_t;

    fr_state_t      state;
    logic [32:0]    sh;                              // top bit drives mosi
    logic [5:0]     bit_cnt;                         // command bits sent
    logic           cmd_fall;                        // sclk falls with a shift

    assign flash_mosi = sh[32];
    assign cmd_fall   = (state == FR_CMD) && flash_sclk && (bit_cnt != 6'd32);

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            state      <= FR_IDLE;
            flash_cs_n <= 1'b1;
            flash_sclk <= 1'b1;                      // clock idles high
            cmd_done   <= 1'b0;
            bit_valid  <= 1'b0;
            bit_cnt    <= 6'd0;
        end
        else
        begin
            cmd_done  <= 1'b0;
            bit_valid <= 1'b0;
            case (state)
                FR_IDLE:
                begin
                    if (cmd_start)
                    begin
                        flash_cs_n <= 1'b0;          // one setup cycle before first fall
                        bit_cnt    <= 6'd0;
                        state      <= FR_CMD;
                    end
                end
                FR_CMD:
                begin
                    if (cmd_fall)
                        flash_sclk <= 1'b0;          // shift below
                    else if (!flash_sclk)
                    begin
                        flash_sclk <= 1'b1;          // flash samples mosi here
                        bit_cnt    <= bit_cnt + 6'd1;
                    end
                    else
                    begin
                        cmd_done <= 1'b1;            // all 32 bits out
                        state    <= FR_READY;
                    end
                end
                FR_READY:
                begin
                    if (bit_req)
                    begin
                        flash_sclk <= 1'b0;          // flash drives next bit
                        state      <= FR_READ;
                    end
                end
                default:
                begin
                    flash_sclk <= 1'b1;              // rise, miso captured below
                    bit_valid  <= 1'b1;
                    state      <= FR_READY;
                end
            endcase
            if (cmd_end)
            begin
                flash_cs_n <= 1'b1;
                flash_sclk <= 1'b1;
                state      <= FR_IDLE;
            end
        end
    end

    // shift register and sampled bit
    always_ff @(posedge MCLK)
    begin
        if ((state == FR_IDLE) && cmd_start)
            sh <= {1'b0, `FLASH_READ_CMD, flash_addr};   // msb first
        else if (cmd_fall)
            sh <= sh << 1;
        if (state == FR_READ)
            bit_data <= flash_miso;                  // same edge as sclk rise
    end

endmodule

//--- design/load_request_reg.sv
`include "spi_loader_settings.svh"

module load_request_reg
(
    input  logic                    MCLK,
    input  logic                    rst,
    input  logic                    load_start,      // one cycle request pulse
    input  bubble_pkg::load_kind_t  load_kind,
    input  flash_pkg::img_num_t     img_num,
    input  flash_pkg::page_num_t    page,
    input  logic                    done,            // from sequencer
    output logic                    busy,
    output logic                    go,              // kicks the sequencer
    output bubble_pkg::load_kind_t  kind,
    output flash_pkg::flash_addr_t  flash_addr
);

    logic                   accept;                  // start while free
    flash_pkg::page_num_t   page_sel;

    assign accept   = load_start && !busy;           // pulses while busy are dropped
    assign page_sel = (load_kind == bubble_pkg::KIND_BOOT) ? `BOOT_PAGE : page;

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            go   <= 1'b0;
        end
        else
        begin
            go <= accept;                            // single cycle
            if (accept)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;                        // low the cycle after done
        end
    end

    // request payload, held for the whole load
    always_ff @(posedge MCLK)
    begin
        if (accept)
        begin
            kind       <= load_kind;
            flash_addr <= '{pad_hi: 2'b00, img: img_num, page: page_sel, byte_off: 7'd0};
        end
    end

endmodule

//--- design/load_sequencer.sv
`include "spi_loader_settings.svh"

module load_sequencer
(
    input  logic                    MCLK,
    input  logic                    rst,
    input  logic                    go,
    input  bubble_pkg::load_kind_t  kind,
    input  logic                    cmd_done,
    input  logic                    bit_valid,
    input  logic                    bit_data,
    input  logic                    map_rdata,
    output logic                    done,
    output logic                    cmd_start,
    output logic                    cmd_end,
    output logic                    bit_req,
    output logic                    map_we,
    output logic                    map_re,
    output bubble_pkg::map_addr_t   map_addr,
    output logic                    map_wdata,
    output bubble_pkg::buf_addr_t   buf_addr,
    output logic                    buf_data,
    output logic                    buf_we
);

    typedef enum logic [1:0]
    {
        S_CHECK,                                     // count check, table read issued
        S_LOOK,                                      // table entry valid
        S_FETCH                                      // waiting on flash bit
    } step_t;

    bubble_pkg::seq_phase_t phase;
    step_t                  step;
    logic [`CNT_W-1:0]      bit_cnt;                 // counted writes in this phase
    logic [`CNT_W-1:0]      cnt_limit;
    logic                   limit_hit;
    logic                   table_phase;             // head or data

    always_comb
    begin
        case (phase)
            bubble_pkg::PH_BOOT: cnt_limit = `CNT_W'(`BOOT_BITS);
            bubble_pkg::PH_MAP:  cnt_limit = `CNT_W'(`MAP_BITS);
            bubble_pkg::PH_HEAD: cnt_limit = `CNT_W'(`PAGE_HEAD_BITS);
            default:             cnt_limit = `CNT_W'(`PAGE_BITS);
        endcase
    end

    assign limit_hit   = (bit_cnt == cnt_limit);
    assign table_phase = (phase == bubble_pkg::PH_HEAD) || (phase == bubble_pkg::PH_DATA);
    assign map_re      = table_phase && (step == S_CHECK) && !limit_hit;

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            phase     <= bubble_pkg::PH_IDLE;
            step      <= S_CHECK;
            bit_cnt   <= '0;
            map_addr  <= '0;
            buf_addr  <= '0;
            cmd_start <= 1'b0;
            cmd_end   <= 1'b0;
            bit_req   <= 1'b0;
            map_we    <= 1'b0;
            buf_we    <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            cmd_start <= 1'b0;
            cmd_end   <= 1'b0;
            bit_req   <= 1'b0;
            map_we    <= 1'b0;
            buf_we    <= 1'b0;
            done      <= cmd_end;                    // one cycle after cs release
            if (buf_we)
                buf_addr <= buf_addr + 15'd1;        // advance after each strobe
            if (map_we)
                map_addr <= map_addr + 12'd1;
            case (phase)
                bubble_pkg::PH_IDLE:
                begin
                    if (go)
                    begin
                        cmd_start <= 1'b1;
                        bit_cnt   <= '0;
                        map_addr  <= '0;
                        buf_addr  <= (kind == bubble_pkg::KIND_BOOT) ?
                                     15'(`BOOT_BUF_BASE) : 15'(`PAGE_BUF_BASE);
                        phase     <= bubble_pkg::PH_CMD;
                    end
                end
                bubble_pkg::PH_CMD:
                begin
                    step <= S_CHECK;
                    if (cmd_done)
                        phase <= (kind == bubble_pkg::KIND_BOOT) ?
                                 bubble_pkg::PH_BOOT : bubble_pkg::PH_HEAD;
                end
                default:
                begin
                    case (step)
                        S_CHECK:
                        begin
                            if (limit_hit)
                            begin
                                bit_cnt <= '0;
                                case (phase)
                                    bubble_pkg::PH_BOOT: phase <= bubble_pkg::PH_MAP;
                                    bubble_pkg::PH_HEAD: phase <= bubble_pkg::PH_DATA;
                                    default:
                                    begin
                                        cmd_end <= 1'b1;     // map or data finished
                                        phase   <= bubble_pkg::PH_IDLE;
                                    end
                                endcase
                            end
                            else if (table_phase)
                                step <= S_LOOK;              // map_re high this cycle
                            else
                            begin
                                bit_req <= 1'b1;
                                step    <= S_FETCH;
                            end
                        end
                        S_LOOK:
                        begin
                            if (map_rdata && (phase == bubble_pkg::PH_DATA))
                            begin
                                bit_req <= 1'b1;             // good loop takes a flash bit
                                step    <= S_FETCH;
                            end
                            else
                            begin
                                buf_data <= map_rdata;       // header 1 or bad loop 0
                                buf_we   <= 1'b1;
                                map_addr <= map_addr + 12'd1;
                                if (map_rdata)
                                    bit_cnt <= bit_cnt + 1'b1;
                                step <= S_CHECK;
                            end
                        end
                        default:
                        begin
                            if (bit_valid)
                            begin
                                buf_data <= bit_data;
                                buf_we   <= 1'b1;
                                bit_cnt  <= bit_cnt + 1'b1;
                                if (phase == bubble_pkg::PH_MAP)
                                    map_we <= 1'b1;          // copy into table as well
                                if (phase == bubble_pkg::PH_DATA)
                                    map_addr <= map_addr + 12'd1;
                                step <= S_CHECK;
                            end
                        end
                    endcase
                end
            endcase
        end
    end

    // map payload follows the flash bit
    always_ff @(posedge MCLK)
    begin
        if (bit_valid)
            map_wdata <= bit_data;
    end

endmodule

//--- design/loop_map_table.sv
module loop_map_table
(
    input  logic                    MCLK,
    input  logic                    rst,
    input  logic                    map_we,
    input  logic                    map_re,
    input  bubble_pkg::map_addr_t   map_addr,
    input  logic                    map_wdata,       // 1 good loop, 0 bad loop
    output logic                    map_rdata        // valid the cycle after map_re
);

    logic mem [0:4095] = '{default: 1'b1};           // one bit per loop, unmapped loops good

    // the map arrives with the low nibble of each index inverted
    always_ff @(posedge MCLK)
    begin
        if (map_we)
            mem[{map_addr[11:4], ~map_addr[3:0]}] <= map_wdata;
    end

    // reads take the plain index
    always_ff @(posedge MCLK)
    begin
        if (rst)
            map_rdata <= 1'b0;
        else if (map_re)
            map_rdata <= mem[map_addr];
    end

endmodule

//--- design/spi_loader_settings.svh
`ifndef SPI_LOADER_SETTINGS_SVH
`define SPI_LOADER_SETTINGS_SVH

// flash side
`define FLASH_READ_CMD  8'h03          // serial read, no dummy cycles
`define BOOT_PAGE       12'h805        // first page of the bootloader block

// stream lengths, counted writes
`define BOOT_BITS       2656           // bootloader body
`define MAP_BITS        1168           // loop map, also stored in table
`define PAGE_HEAD_BITS  6              // good header loops per page
`define PAGE_BITS       1030           // good data loops per page

// bubble buffer start addresses
`define BOOT_BUF_BASE   4106           // boot image lands here
`define PAGE_BUF_BASE   14336          // page image lands here

// bit counter width, must hold the largest count above
`define CNT_W           12

`endif

//--- design/spi_loader_top.sv
module spi_loader_top
(
    input  logic                    MCLK,
    input  logic                    rst,
    input  logic                    load_start,
    input  bubble_pkg::load_kind_t  load_kind,
    input  flash_pkg::img_num_t     img_num,
    input  flash_pkg::page_num_t    page,
    output logic                    busy,
    output bubble_pkg::buf_addr_t   buf_addr,
    output logic                    buf_data,
    output logic                    buf_we,
    output logic                    flash_cs_n,
    output logic                    flash_sclk,
    output logic                    flash_mosi,
    input  logic                    flash_miso
);

    logic                   go;
    logic                   done;
    bubble_pkg::load_kind_t kind;
    flash_pkg::flash_addr_t flash_addr;
    logic                   cmd_start;
    logic                   cmd_end;
    logic                   cmd_done;
    logic                   bit_req;
    logic                   bit_valid;
    logic                   bit_data;
    logic                   map_we;
    logic                   map_re;
    bubble_pkg::map_addr_t  map_addr;
    logic                   map_wdata;
    logic                   map_rdata;

    load_request_reg u_req
    (
        .MCLK(MCLK), .rst(rst), .load_start(load_start), .load_kind(load_kind),
        .img_num(img_num), .page(page), .done(done),
        .busy(busy), .go(go), .kind(kind), .flash_addr(flash_addr)
    );

    load_sequencer u_seq
    (
        .MCLK(MCLK), .rst(rst), .go(go), .kind(kind), .cmd_done(cmd_done),
        .bit_valid(bit_valid), .bit_data(bit_data), .map_rdata(map_rdata),
        .done(done), .cmd_start(cmd_start), .cmd_end(cmd_end), .bit_req(bit_req),
        .map_we(map_we), .map_re(map_re), .map_addr(map_addr), .map_wdata(map_wdata),
        .buf_addr(buf_addr), .buf_data(buf_data), .buf_we(buf_we)
    );

    flash_reader u_flash
    (
        .MCLK(MCLK), .rst(rst), .flash_addr(flash_addr), .cmd_start(cmd_start),
        .cmd_end(cmd_end), .bit_req(bit_req), .flash_miso(flash_miso),
        .cmd_done(cmd_done), .bit_valid(bit_valid), .bit_data(bit_data),
        .flash_cs_n(flash_cs_n), .flash_sclk(flash_sclk), .flash_mosi(flash_mosi)
    );

    loop_map_table u_map
    (
        .MCLK(MCLK), .rst(rst), .map_we(map_we), .map_re(map_re),
        .map_addr(map_addr), .map_wdata(map_wdata), .map_rdata(map_rdata)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the loader testbench with verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
        -f all.f --top-module tb_spi_loader -o sim_spi_loader; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_spi_loader)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

//--- verif/spi_flash_model.sv
module spi_flash_model
(
    input  logic        cs_n,
    input  logic        sclk,
    input  logic        mosi,
    output logic        miso,
    output logic [31:0] cmd_word,                   // last command and address received
    output int          cmd_count                   // commands received so far
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h601b;

    int          sel_count = 0;                     // chip selects seen
    int          sel_served = 0;                    // selects already started on
    int          rx_cnt = 0;                        // command bits in
    logic [31:0] rx_shift = '0;
    logic [31:0] lfsr = SEED;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial
    begin
        miso      = 1'b0;
        cmd_word  = '0;
        cmd_count = 0;
    end

    always @(negedge cs_n)
        sel_count++;                                // new transaction

    always @(posedge sclk or negedge sclk)
    begin
        if (cs_n === 1'b0)
        begin
            if (sel_served != sel_count)
            begin
                sel_served = sel_count;             // first edge after select
                rx_cnt     = 0;
                lfsr       = SEED;                  // restart stream per select
            end
            if (sclk && rx_cnt < 32)
            begin
                rx_shift = {rx_shift[30:0], mosi};  // msb first
                rx_cnt++;
                if (rx_cnt == 32)
                begin
                    cmd_word = rx_shift;
                    cmd_count++;
                end
            end
            else if (!sclk && rx_cnt == 32)
            begin
                miso = lfsr[31];                    // held until the rise
                lfsr = lfsr_next(lfsr);             // one step per bit
            end
        end
    end

endmodule

//--- verif/spi_loader_cases.txt
// one load per line, hex: kind (0 boot, 1 page), image number, page number
// first load is a boot so the loop table holds the map
0 0 000
1 2 123
1 7 fff
0 5 3a0
1 0 001
1 4 abc

//--- verif/tb_spi_loader.sv
`include "spi_loader_settings.svh"

module tb_spi_loader;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAX_CASES = 32;
    localparam logic [31:0] SEED = 32'h601b;
    localparam int          WALK = 4096;            // a page walks at most one table pass

    logic                   MCLK;
    logic                   rst;
    logic                   load_start;
    bubble_pkg::load_kind_t load_kind;
    flash_pkg::img_num_t    img_num;
    flash_pkg::page_num_t   page;
    logic                   busy;
    bubble_pkg::buf_addr_t  buf_addr;
    logic                   buf_data;
    logic                   buf_we;
    logic                   flash_cs_n;
    logic                   flash_sclk;
    logic                   flash_mosi;
    logic                   flash_miso;
    logic [31:0]            cmd_word;
    int                     cmd_count;

    logic [15:0]            case_mem [0:3*MAX_CASES-1];  // kind, image, page per case
    bit                     ref_map [0:4095];            // reference bad-loop table, 1 good
    int                     exp_addr [$];                // expected buffer writes
    bit                     exp_data [$];
    int                     n_cases = 0;
    int                     writes = 0;
    int                     test_errors = 0;
    int                     errors = 0;
    int                     failed = 0;
    int                     cycles = 0;
    int                     cycle_limit = 1000;

    spi_loader_top u_dut
    (
        .MCLK(MCLK), .rst(rst), .load_start(load_start), .load_kind(load_kind),
        .img_num(img_num), .page(page), .busy(busy), .buf_addr(buf_addr),
        .buf_data(buf_data), .buf_we(buf_we), .flash_cs_n(flash_cs_n),
        .flash_sclk(flash_sclk), .flash_mosi(flash_mosi), .flash_miso(flash_miso)
    );

    spi_flash_model u_flash
    (
        .cs_n(flash_cs_n), .sclk(flash_sclk), .mosi(flash_mosi), .miso(flash_miso),
        .cmd_word(cmd_word), .cmd_count(cmd_count)
    );

    always #50 MCLK = ~MCLK;                        // 100 ns period

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // same taps as flash
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            test_errors++;
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("at %0t ns: %s", $time, what);
        test_errors++;
        errors++;
    endtask

    // boot: bootloader bits then map bits, map also lands in the table
    task automatic queue_boot_writes();
        logic [31:0] st;
        logic [11:0] idx;
        st = SEED;
        for (int k = 0; k < `BOOT_BITS + `MAP_BITS; k++)
        begin
            exp_addr.push_back(`BOOT_BUF_BASE + k);
            exp_data.push_back(st[31]);
            if (k >= `BOOT_BITS)
            begin
                idx = 12'((k - `BOOT_BITS) ^ 'hf);  // low nibble flipped
                ref_map[idx] = st[31];
            end
            st = lfsr_next(st);
        end
    endtask

    // page: table walk from 0, header then data
    task automatic walk_page_table();
        logic [31:0] st;
        logic [11:0] idx;
        int          addr;
        int          good;
        int          guard;
        st    = SEED;
        idx   = '0;
        addr  = `PAGE_BUF_BASE;
        good  = 0;
        guard = 0;
        while (good < `PAGE_HEAD_BITS && guard < WALK)
        begin
            exp_addr.push_back(addr++);
            exp_data.push_back(ref_map[idx]);       // header writes the entry itself
            if (ref_map[idx])
                good++;
            idx++;                                  // wraps at 4096
            guard++;
        end
        good = 0;
        while (good < `PAGE_BITS && guard < WALK)
        begin
            exp_addr.push_back(addr++);
            if (ref_map[idx])
            begin
                exp_data.push_back(st[31]);         // good loop takes a flash bit
                st = lfsr_next(st);
                good++;
            end
            else
                exp_data.push_back(1'b0);
            idx++;
            guard++;
        end
        if (guard >= WALK)
            report_failure("loop table holds too few good loops for one page");
    endtask

    task automatic run_case(input int n);
        bubble_pkg::load_kind_t kind;
        logic [2:0]             img;
        logic [11:0]            pg;
        logic [11:0]            pg_sent;
        int                     cmds_before;
        int                     exp_writes;
        kind        = bubble_pkg::load_kind_t'(case_mem[3*n][0]);
        img         = case_mem[3*n+1][2:0];
        pg          = case_mem[3*n+2][11:0];
        test_errors = 0;
        writes      = 0;
        cmds_before = cmd_count;
        if (kind == bubble_pkg::KIND_BOOT)
        begin
            queue_boot_writes();
            pg_sent = `BOOT_PAGE;                   // requested page ignored
        end
        else
        begin
            walk_page_table();
            pg_sent = pg;
        end
        exp_writes = exp_addr.size();
        @(posedge MCLK);
        load_start <= 1'b1;
        load_kind  <= kind;
        img_num    <= img;
        page       <= pg;
        @(posedge MCLK);
        load_start <= 1'b0;
        @(posedge MCLK);
        check_value("busy", 32'(busy), 32'd1);
        repeat (3) @(posedge MCLK);
        load_start <= 1'b1;                         // must be dropped, busy is high
        load_kind  <= bubble_pkg::KIND_PAGE;
        img_num    <= ~img;
        page       <= ~pg;
        @(posedge MCLK);
        load_start <= 1'b0;
        while (busy)
            @(posedge MCLK);
        check_value("commands sent", cmd_count - cmds_before, 32'd1);
        check_value("cmd_word", cmd_word, {`FLASH_READ_CMD, 2'b00, img, pg_sent, 7'd0});
        check_value("write count", 32'(writes), 32'(exp_writes));
        if (exp_addr.size() != 0)
            report_failure("busy fell before all expected buffer writes came");
        exp_addr.delete();
        exp_data.delete();
        $display("test %0d: %s image %0d page %03h, %0d writes, %0d errors, %s", n,
                 (kind == bubble_pkg::KIND_BOOT) ? "boot" : "page", img, pg, writes,
                 test_errors, (test_errors == 0) ? "ok" : "failed");
        if (test_errors != 0)
            failed++;
        repeat (4) @(posedge MCLK);                 // idle gap
    endtask

    // write monitor and idle check, sampled before the edge updates
    always @(posedge MCLK)
    begin
        if (!rst)
        begin
            if (!busy)
            begin
                check_value("flash_cs_n", 32'(flash_cs_n), 32'd1);
                check_value("flash_sclk", 32'(flash_sclk), 32'd1);   // clock parks high
            end
            if (buf_we)
            begin
                if (exp_addr.size() == 0)
                    report_failure("buffer write when none was expected");
                else
                begin
                    check_value("buf_addr", 32'(buf_addr), 32'(exp_addr.pop_front()));
                    check_value("buf_data", 32'(buf_data), 32'(exp_data.pop_front()));
                    writes++;
                end
            end
        end
    end

    always @(posedge MCLK)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial
    begin
        MCLK       = 1'b0;
        rst        = 1'b1;
        load_start = 1'b0;
        load_kind  = bubble_pkg::KIND_BOOT;
        img_num    = '0;
        page       = '0;
        for (int k = 0; k < 4096; k++)
            ref_map[k] = 1'b1;                      // loops outside the map are good
        for (int k = 0; k < 3 * MAX_CASES; k++)
            case_mem[k] = 16'hffff;                 // end marker
        $readmemh("verif/spi_loader_cases.txt", case_mem);
        while (n_cases < MAX_CASES && case_mem[3*n_cases] != 16'hffff)
        begin
            if (case_mem[3*n_cases][0])             // page: counted bits plus table walk
                cycle_limit += 8 * (`PAGE_HEAD_BITS + `PAGE_BITS) + 6 * WALK + 200;
            else
                cycle_limit += 8 * (`BOOT_BITS + `MAP_BITS) + 6 * `MAP_BITS + 200;
            n_cases++;
        end
        if (n_cases == 0 || case_mem[0] != 16'h0)
            report_failure("case file is empty or does not start with a boot load");
        repeat (10) @(posedge MCLK);
        rst <= 1'b0;
        repeat (2) @(posedge MCLK);
        for (int k = 0; k < n_cases; k++)
            run_case(k);
        $display("done: %0d tests, %0d failed, %0d errors", n_cases, failed, errors);
        if (failed == 0 && errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
